// ==== common/mm_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// matrix-multiply accelerator shared definitions
// sizes, element and accumulator types, AXI field codes, FSM codes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mm_pkg;

    // element and matrix geometry
    localparam int DW     = 32;
    localparam int SA_N   = 4;
    localparam int ACC_W  = 2 * DW + 1;
    localparam int BUF_AW = 2;
    localparam int BUF_DW = SA_N * DW;

    // AXI3 field widths
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 4;

    // burst shape, 16 beats of 4 bytes
    localparam int BURST_LEN = 16;
    localparam logic [LEN_W-1:0] AXI_LEN = LEN_W'(BURST_LEN - 1);
    localparam logic [2:0] AXI_SIZE = 3'd2;
    localparam logic [1:0] AXI_INCR = 2'd1;

    // read ids, A on 0 and B on 1
    localparam logic [ID_W-1:0] ID_A = ID_W'(0);
    localparam logic [ID_W-1:0] ID_B = ID_W'(1);

    // dma FSM encoding
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [ST_W-1:0] ST_ADDR_A  = 3'd1;
    localparam logic [ST_W-1:0] ST_ADDR_B  = 3'd2;
    localparam logic [ST_W-1:0] ST_LOAD    = 3'd3;
    localparam logic [ST_W-1:0] ST_WAIT_MM = 3'd4;
    localparam logic [ST_W-1:0] ST_ADDR_C  = 3'd5;
    localparam logic [ST_W-1:0] ST_WRITE_C = 3'd6;

    typedef logic signed [DW-1:0] elem_t;

    // element 0 in the top bits, beats shift in from the bottom
    typedef elem_t [0:SA_N-1] buf_word_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // row then column
    typedef acc_t [0:SA_N-1][0:SA_N-1] acc_matrix_t;

endpackage

`default_nettype wire

// ==== common/axi_rd_if.sv ====
//////////////////////////////////////////////////////////////////////
// AXI3 read channels, address and data
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface axi_rd_if
    import mm_pkg::*;
();

    // read address channel
    logic              arvalid;
    logic              arready;
    logic [ID_W-1:0]   arid;
    logic [ADDR_W-1:0] araddr;
    logic [LEN_W-1:0]  arlen;
    logic [2:0]        arsize;
    logic [1:0]        arburst;

    // read data channel
    logic              rvalid;
    logic              rready;
    logic [ID_W-1:0]   rid;
    logic [DW-1:0]     rdata;
    logic              rlast;

    modport master (
        output arvalid, arid, araddr, arlen, arsize, arburst, rready,
        input  arready, rvalid, rid, rdata, rlast
    );

    modport slave (
        input  arvalid, arid, araddr, arlen, arsize, arburst, rready,
        output arready, rvalid, rid, rdata, rlast
    );

endinterface

`default_nettype wire

// ==== common/axi_wr_if.sv ====
//////////////////////////////////////////////////////////////////////
// AXI3 write channels, address, data and response
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface axi_wr_if
    import mm_pkg::*;
();

    // write address channel
    logic              awvalid;
    logic              awready;
    logic [ID_W-1:0]   awid;
    logic [ADDR_W-1:0] awaddr;
    logic [LEN_W-1:0]  awlen;
    logic [2:0]        awsize;
    logic [1:0]        awburst;

    // write data channel
    logic              wvalid;
    logic              wready;
    logic [ID_W-1:0]   wid;
    logic [DW-1:0]     wdata;
    logic [DW/8-1:0]   wstrb;
    logic              wlast;

    // write response channel
    logic              bvalid;
    logic              bready;
    logic [ID_W-1:0]   bid;
    logic [1:0]        bresp;

    modport master (
        output awvalid, awid, awaddr, awlen, awsize, awburst,
        output wvalid, wid, wdata, wstrb, wlast, bready,
        input  awready, wready, bvalid, bid, bresp
    );

    modport slave (
        input  awvalid, awid, awaddr, awlen, awsize, awburst,
        input  wvalid, wid, wdata, wstrb, wlast, bready,
        output awready, wready, bvalid, bid, bresp
    );

endinterface

`default_nettype wire

// ==== logic/operand_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// operand buffer, four 128-bit words
// synchronous write, registered read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operand_buffer
    import mm_pkg::*;
(
    input  logic              clk,
    input  logic              wren_i,
    input  logic [BUF_AW-1:0] waddr_i,
    input  buf_word_t         wdata_i,
    input  logic [BUF_AW-1:0] raddr_i,
    output buf_word_t         rdata_o
);

    // one word per column of A or row of B
    buf_word_t mem_q [SA_N];

    always_ff @(posedge clk) begin
        if (wren_i)
            mem_q[waddr_i] <= wdata_i;
    end

    // data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

`default_nettype wire

// ==== mm/mm_engine.sv ====
//////////////////////////////////////////////////////////////////////
// outer-product multiply engine, 4x4 signed
// accumulates A column k times B row k over four buffer reads
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mm_engine
    import mm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    output logic              done_o,
    output logic [BUF_AW-1:0] raddr_o,
    input  buf_word_t         a_col_i,
    input  buf_word_t         b_row_i,
    output acc_matrix_t       accum_o
);

    // read issue, address 0 goes out in the start cycle
    logic              busy_q;
    logic [BUF_AW-1:0] step_q;

    // buffer data returning
    logic              data_v_q;
    logic              data_last_q;

    // product stage
    acc_matrix_t       prod_q;
    logic              prod_v_q;
    logic              prod_last_q;

    assign raddr_o = busy_q ? step_q : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            step_q      <= '0;
            data_v_q    <= 1'b0;
            data_last_q <= 1'b0;
            prod_v_q    <= 1'b0;
            prod_last_q <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            if (start_i) begin
                busy_q <= 1'b1;
                step_q <= BUF_AW'(1);
            end else if (busy_q) begin
                step_q <= step_q + BUF_AW'(1);
                busy_q <= (step_q != BUF_AW'(SA_N - 1));
            end
            data_v_q    <= start_i || busy_q;
            data_last_q <= busy_q && (step_q == BUF_AW'(SA_N - 1));
            prod_v_q    <= data_v_q;
            prod_last_q <= data_last_q;
            // last product added, result settles
            done_o      <= prod_v_q && prod_last_q;
        end
    end

    // multiply one pair while the previous one accumulates
    always_ff @(posedge clk) begin
        for (int i = 0; i < SA_N; i++) begin
            for (int j = 0; j < SA_N; j++) begin
                // sign-extended to accumulator width
                if (data_v_q)
                    prod_q[i][j] <= $signed(a_col_i[i]) * $signed(b_row_i[j]);
                if (start_i)
                    accum_o[i][j] <= '0;
                else if (prod_v_q)
                    accum_o[i][j] <= accum_o[i][j] + prod_q[i][j];
            end
        end
    end

endmodule

`default_nettype wire

// ==== dma/dma_engine.sv ====
//////////////////////////////////////////////////////////////////////
// DMA engine that reads A and B over AXI into the operand buffers,
// starts the multiply and writes C back as one 16-beat burst
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_engine
    import mm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] mat_a_addr_i,
    input  logic [ADDR_W-1:0] mat_b_addr_i,
    input  logic [ADDR_W-1:0] mat_c_addr_i,
    input  logic              start_i,
    output logic              done_o,
    axi_rd_if.master          rd,
    axi_wr_if.master          wr,
    output logic              buf_a_wren_o,
    output logic              buf_b_wren_o,
    output logic [BUF_AW-1:0] buf_waddr_o,
    output buf_word_t         buf_wdata_o,
    output logic              mm_start_o,
    input  logic              mm_done_i,
    input  acc_matrix_t       accum_i
);

    logic [ST_W-1:0] state_q;
    logic [ST_W-1:0] state_d;

    // per-id load state with index 0 for A and 1 for B
    buf_word_t       shift_q [2];
    logic [1:0]      beat_q  [2];
    logic [2:0]      word_q  [2];

    // write-back beat with the row in the top two bits
    logic [3:0]      wbeat_q;
    logic            w_done_q;

    logic            r_fire;
    logic            r_sel;
    logic            word_end;
    buf_word_t       r_word;
    logic            w_fire;
    logic            b_fire;
    logic            load_done;

    assign r_fire    = rd.rvalid && rd.rready;
    assign r_sel     = (rd.rid == ID_B);
    assign word_end  = r_fire && (beat_q[r_sel] == 2'd3);
    // new beat enters at the bottom
    assign r_word    = {shift_q[r_sel][1:SA_N-1], rd.rdata};
    assign load_done = (word_q[0] == 3'(SA_N)) && (word_q[1] == 3'(SA_N));
    assign w_fire    = wr.wvalid && wr.wready;
    assign b_fire    = wr.bvalid && wr.bready;

    assign done_o = (state_q == ST_IDLE);

    // AR for A first and for B once A is accepted
    assign rd.arvalid = (state_q == ST_ADDR_A) || (state_q == ST_ADDR_B);
    assign rd.arid    = (state_q == ST_ADDR_B) ? ID_B : ID_A;
    assign rd.araddr  = (state_q == ST_ADDR_B) ? mat_b_addr_i : mat_a_addr_i;
    assign rd.arlen   = AXI_LEN;
    assign rd.arsize  = AXI_SIZE;
    assign rd.arburst = AXI_INCR;
    // A beats may already flow while B address waits
    assign rd.rready  = (state_q == ST_ADDR_B) || (state_q == ST_LOAD);

    // AW and W for the C burst
    assign wr.awvalid = (state_q == ST_ADDR_C);
    assign wr.awid    = '0;
    assign wr.awaddr  = mat_c_addr_i;
    assign wr.awlen   = AXI_LEN;
    assign wr.awsize  = AXI_SIZE;
    assign wr.awburst = AXI_INCR;
    assign wr.wvalid  = (state_q == ST_WRITE_C) && !w_done_q;
    assign wr.wid     = '0;
    // C keeps the low word of each accumulator in row-major order
    assign wr.wdata   = accum_i[wbeat_q[3:2]][wbeat_q[1:0]][DW-1:0];
    assign wr.wstrb   = '1;
    assign wr.wlast   = (wbeat_q == 4'(BURST_LEN - 1));
    // response only after the last beat went out
    assign wr.bready  = (state_q == ST_WRITE_C) && w_done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (start_i)
                    state_d = ST_ADDR_A;
            ST_ADDR_A:
                if (rd.arready)
                    state_d = ST_ADDR_B;
            ST_ADDR_B:
                if (rd.arready)
                    state_d = ST_LOAD;
            ST_LOAD:
                if (load_done)
                    state_d = ST_WAIT_MM;
            ST_WAIT_MM:
                if (mm_done_i)
                    state_d = ST_ADDR_C;
            ST_ADDR_C:
                if (wr.awready)
                    state_d = ST_WRITE_C;
            ST_WRITE_C:
                if (b_fire)
                    state_d = ST_IDLE;
            default:
                state_d = ST_IDLE;
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            beat_q       <= '{default: '0};
            word_q       <= '{default: '0};
            wbeat_q      <= '0;
            w_done_q     <= 1'b0;
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
            mm_start_o   <= 1'b0;
        end else begin
            state_q      <= state_d;
            buf_a_wren_o <= word_end && !r_sel;
            buf_b_wren_o <= word_end && r_sel;
            // single pulse as the last word lands
            mm_start_o   <= (state_q == ST_LOAD) && load_done;
            if ((state_q == ST_IDLE) && start_i) begin
                beat_q   <= '{default: '0};
                word_q   <= '{default: '0};
                wbeat_q  <= '0;
                w_done_q <= 1'b0;
            end
            if (r_fire) begin
                beat_q[r_sel] <= beat_q[r_sel] + 2'd1;
            end
            if (word_end) begin
                word_q[r_sel] <= word_q[r_sel] + 3'd1;
            end
            if (w_fire) begin
                wbeat_q <= wbeat_q + 4'd1;
                if (wr.wlast)
                    w_done_q <= 1'b1;
            end
        end
    end

    // beat packing with the buffer write in the cycle after the 4th beat
    always_ff @(posedge clk) begin
        if (r_fire) begin
            shift_q[r_sel] <= r_word;
            buf_wdata_o    <= r_word;
            buf_waddr_o    <= word_q[r_sel][BUF_AW-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mm_accel_top.sv ====
//////////////////////////////////////////////////////////////////////
// matrix-multiply accelerator top level
// dma engine, two operand buffers and the multiply engine
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mm_accel_top
    import mm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] mat_a_addr_i,
    input  logic [ADDR_W-1:0] mat_b_addr_i,
    input  logic [ADDR_W-1:0] mat_c_addr_i,
    input  logic              start_i,
    output logic              done_o,
    // AXI read
    output logic              arvalid_o,
    input  logic              arready_i,
    output logic [ID_W-1:0]   arid_o,
    output logic [ADDR_W-1:0] araddr_o,
    output logic [LEN_W-1:0]  arlen_o,
    output logic [2:0]        arsize_o,
    output logic [1:0]        arburst_o,
    input  logic              rvalid_i,
    output logic              rready_o,
    input  logic [ID_W-1:0]   rid_i,
    input  logic [DW-1:0]     rdata_i,
    input  logic              rlast_i,
    // AXI write
    output logic              awvalid_o,
    input  logic              awready_i,
    output logic [ID_W-1:0]   awid_o,
    output logic [ADDR_W-1:0] awaddr_o,
    output logic [LEN_W-1:0]  awlen_o,
    output logic [2:0]        awsize_o,
    output logic [1:0]        awburst_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output logic [ID_W-1:0]   wid_o,
    output logic [DW-1:0]     wdata_o,
    output logic [DW/8-1:0]   wstrb_o,
    output logic              wlast_o,
    input  logic              bvalid_i,
    output logic              bready_o,
    input  logic [ID_W-1:0]   bid_i,
    input  logic [1:0]        bresp_i
);

    axi_rd_if rd_if ();
    axi_wr_if wr_if ();

    logic              buf_a_wren;
    logic              buf_b_wren;
    logic [BUF_AW-1:0] buf_waddr;
    buf_word_t         buf_wdata;
    logic [BUF_AW-1:0] buf_raddr;
    buf_word_t         a_col;
    buf_word_t         b_row;
    logic              mm_start;
    logic              mm_done;
    acc_matrix_t       accum;

    // read side of the bus
    assign arvalid_o      = rd_if.arvalid;
    assign rd_if.arready  = arready_i;
    assign arid_o         = rd_if.arid;
    assign araddr_o       = rd_if.araddr;
    assign arlen_o        = rd_if.arlen;
    assign arsize_o       = rd_if.arsize;
    assign arburst_o      = rd_if.arburst;
    assign rd_if.rvalid   = rvalid_i;
    assign rready_o       = rd_if.rready;
    assign rd_if.rid      = rid_i;
    assign rd_if.rdata    = rdata_i;
    assign rd_if.rlast    = rlast_i;

    // write side of the bus
    assign awvalid_o      = wr_if.awvalid;
    assign wr_if.awready  = awready_i;
    assign awid_o         = wr_if.awid;
    assign awaddr_o       = wr_if.awaddr;
    assign awlen_o        = wr_if.awlen;
    assign awsize_o       = wr_if.awsize;
    assign awburst_o      = wr_if.awburst;
    assign wvalid_o       = wr_if.wvalid;
    assign wr_if.wready   = wready_i;
    assign wid_o          = wr_if.wid;
    assign wdata_o        = wr_if.wdata;
    assign wstrb_o        = wr_if.wstrb;
    assign wlast_o        = wr_if.wlast;
    assign wr_if.bvalid   = bvalid_i;
    assign bready_o       = wr_if.bready;
    assign wr_if.bid      = bid_i;
    assign wr_if.bresp    = bresp_i;

    dma_engine dma_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .rd           (rd_if),
        .wr           (wr_if),
        .buf_a_wren_o (buf_a_wren),
        .buf_b_wren_o (buf_b_wren),
        .buf_waddr_o  (buf_waddr),
        .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    // A holds columns, B holds rows
    operand_buffer buf_a_i (
        .clk     (clk),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (buf_raddr),
        .rdata_o (a_col)
    );

    operand_buffer buf_b_i (
        .clk     (clk),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (buf_raddr),
        .rdata_o (b_row)
    );

    mm_engine mm_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mm_start),
        .done_o  (mm_done),
        .raddr_o (buf_raddr),
        .a_col_i (a_col),
        .b_row_i (b_row),
        .accum_o (accum)
    );

endmodule

`default_nettype wire

// ==== sim/mm_accel_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// AXI port protocol checks, bound to the accelerator top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mm_accel_asserts
    import mm_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              done_i,
    input logic              arvalid_i,
    input logic              arready_i,
    input logic [ID_W-1:0]   arid_i,
    input logic [ADDR_W-1:0] araddr_i,
    input logic [LEN_W-1:0]  arlen_i,
    input logic [2:0]        arsize_i,
    input logic [1:0]        arburst_i,
    input logic              awvalid_i,
    input logic              awready_i,
    input logic [ADDR_W-1:0] awaddr_i,
    input logic [LEN_W-1:0]  awlen_i,
    input logic [2:0]        awsize_i,
    input logic [1:0]        awburst_i,
    input logic              wvalid_i,
    input logic              wready_i,
    input logic [DW-1:0]     wdata_i,
    input logic              wlast_i
);

    // accepted W beats modulo 16
    logic [3:0] w_beats;

    // failed checks so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n)
            w_beats <= '0;
        else if (wvalid_i && wready_i)
            w_beats <= w_beats + 4'd1;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable({arid_i, araddr_i, arlen_i}))
        else begin
            fail_count++;
            $error("AR valid dropped or payload changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable({awaddr_i, awlen_i}))
        else begin
            fail_count++;
            $error("AW valid dropped or payload changed before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable({wdata_i, wlast_i}))
        else begin
            fail_count++;
            $error("W valid dropped or payload changed before wready");
        end

    // burst shape on both address channels
    ar_shape: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i |-> arlen_i == 4'd15 && arsize_i == 3'd2 && arburst_i == 2'd1)
        else begin
            fail_count++;
            $error("AR burst fields wrong");
        end

    aw_shape: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i |-> awlen_i == 4'd15 && awsize_i == 3'd2 && awburst_i == 2'd1)
        else begin
            fail_count++;
            $error("AW burst fields wrong");
        end

    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i |-> wlast_i == (w_beats == 4'd15))
        else begin
            fail_count++;
            $error("wlast not on the 16th beat only");
        end

    // idle and quiet right after reset
    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> done_i && !arvalid_i && !awvalid_i && !wvalid_i)
        else begin
            fail_count++;
            $error("not idle after reset");
        end

endmodule

bind mm_accel_top mm_accel_asserts asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .done_i    (done_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .arid_i    (arid_o),
    .araddr_i  (araddr_o),
    .arlen_i   (arlen_o),
    .arsize_i  (arsize_o),
    .arburst_i (arburst_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .awaddr_i  (awaddr_o),
    .awlen_i   (awlen_o),
    .awsize_i  (awsize_o),
    .awburst_i (awburst_o),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_i   (wdata_o),
    .wlast_i   (wlast_o)
);

`default_nettype wire

// ==== sim/mm_accel_tb.sv ====
//////////////////////////////////////////////////////////////////////
// matrix-multiply accelerator testbench
// AXI memory slave with random stalls, two runs, result checking
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mm_accel_tb
    import mm_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] mat_a_addr_i, mat_b_addr_i, mat_c_addr_i;
    logic              start_i, done_o;
    logic              arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;
    logic [ID_W-1:0]   arid_o, rid_i, awid_o, wid_o, bid_i;
    logic [ADDR_W-1:0] araddr_o, awaddr_o;
    logic [LEN_W-1:0]  arlen_o, awlen_o;
    logic [2:0]        arsize_o, awsize_o;
    logic [1:0]        arburst_o, awburst_o, bresp_i;
    logic [DW-1:0]     rdata_i, wdata_o;
    logic              awvalid_o, awready_i, wvalid_o, wready_i, wlast_o;
    logic              bvalid_i, bready_o;
    logic [DW/8-1:0]   wstrb_o;

    // word-addressed memory behind the slave
    logic [31:0] mem [0:1023];
    logic [31:0] exp_c [16];
    integer      seed = 32'hd7cba276;
    int          err_count = 0;
    int          timeout_count = 0;

    // slave bookkeeping indexed by read id
    logic [9:0]  rd_base [2];
    int          rd_cnt [2];
    bit          rd_act [2];
    int          cur_id;
    logic [9:0]  wr_base;
    logic [ID_W-1:0] wr_id;
    int          wr_cnt, ar_count, aw_count, w_count, b_count;

    mm_accel_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [9:0] word_index(input logic [31:0] addr, input int off);
        return 10'((addr >> 2) + off);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            err_count++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = dut_i.asserts_i.fail_count;
        $display("checks failed: %0d, timeouts: %0d, assertion failures: %0d",
                 err_count, timeout_count, assert_fails);
        if (err_count == 0 && timeout_count == 0 && assert_fails == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    task automatic wait_done(input logic level, input string what);
        int n;
        n = 0;
        while (done_o !== level && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (done_o !== level) begin
            timeout_count++;
            $display("timeout: done_o did not %s", what);
            finish_run();
        end
    endtask

    // AXI slave with interleaved read ids and random stalls
    always @(posedge clk) begin : axi_slave
        bit a_ok;
        bit b_ok;
        if (!rst_n) begin
            arready_i <= 1'b0;
            rvalid_i  <= 1'b0;
            awready_i <= 1'b0;
            wready_i  <= 1'b0;
            bvalid_i  <= 1'b0;
            rd_act    = '{default: 1'b0};
        end else begin
            arready_i <= ($random(seed) & 3) != 0;
            awready_i <= ($random(seed) & 3) != 0;
            wready_i  <= ($random(seed) & 1) != 0;
            if (arvalid_o && arready_i) begin
                // A goes first, then B
                check_value("arid_o", ar_count, arid_o);
                check_value("araddr_o", (ar_count == 0) ? mat_a_addr_i : mat_b_addr_i,
                            araddr_o);
                rd_base[arid_o[0]] = word_index(araddr_o, 0);
                rd_cnt[arid_o[0]]  = 0;
                rd_act[arid_o[0]]  = 1'b1;
                ar_count++;
            end
            if (rvalid_i && rready_o) begin
                rd_cnt[cur_id]++;
                if (rd_cnt[cur_id] == BURST_LEN)
                    rd_act[cur_id] = 1'b0;
            end
            // maybe leave a gap once the beat slot is free
            if (!rvalid_i || rready_o) begin
                a_ok = rd_act[0];
                b_ok = rd_act[1];
                if ((a_ok || b_ok) && ($random(seed) & 3) != 0) begin
                    if (a_ok && b_ok)
                        cur_id = $random(seed) & 1;
                    else
                        cur_id = b_ok;
                    rvalid_i <= 1'b1;
                    rid_i    <= ID_W'(cur_id);
                    rdata_i  <= mem[rd_base[cur_id] + 10'(rd_cnt[cur_id])];
                    rlast_i  <= (rd_cnt[cur_id] == BURST_LEN - 1);
                end else begin
                    rvalid_i <= 1'b0;
                end
            end
            if (awvalid_o && awready_i) begin
                check_value("awaddr_o", mat_c_addr_i, awaddr_o);
                wr_base = word_index(awaddr_o, 0);
                wr_id   = awid_o;
                wr_cnt  = 0;
                aw_count++;
            end
            if (wvalid_o && wready_i) begin
                check_value("wdata_o", exp_c[wr_cnt & 15], wdata_o);
                check_value("wlast_o", wr_cnt == BURST_LEN - 1, wlast_o);
                // AXI3 write data carries the id of its address
                check_value("wid_o", wr_id, wid_o);
                // every C beat is a whole word
                check_value("wstrb_o", 4'hf, wstrb_o);
                mem[wr_base + 10'(wr_cnt)] = wdata_o;
                wr_cnt++;
                w_count++;
                if (wlast_o)
                    bvalid_i <= 1'b1;
            end
            if (bvalid_i && bready_o) begin
                bvalid_i <= 1'b0;
                b_count++;
            end
        end
    end

    // one multiply from fresh matrices with small or full-range operands
    task automatic run_matmul(input logic [31:0] a_addr, input logic [31:0] b_addr,
                              input logic [31:0] c_addr, input bit wide);
        int     a [4][4];
        int     b [4][4];
        longint acc;
        @(negedge clk);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                a[r][c] = wide ? $random(seed) : $random(seed) % 100;
                b[r][c] = wide ? $random(seed) : $random(seed) % 100;
            end
        end
        // A column-major, B row-major
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                mem[word_index(a_addr, 4 * c + r)] = a[r][c];
                mem[word_index(b_addr, 4 * r + c)] = b[r][c];
                acc = 0;
                for (int k = 0; k < 4; k++)
                    acc += longint'(a[r][k]) * longint'(b[k][c]);
                exp_c[4 * r + c] = acc[31:0];
            end
        end
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
        b_count  = 0;
        @(posedge clk);
        mat_a_addr_i <= a_addr;
        mat_b_addr_i <= b_addr;
        mat_c_addr_i <= c_addr;
        start_i      <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        wait_done(1'b0, "fall after start");
        wait_done(1'b1, "return after the write response");
        check_value("read bursts", 2, ar_count);
        check_value("write bursts", 1, aw_count);
        check_value("write beats", BURST_LEN, w_count);
        check_value("write responses", 1, b_count);
    endtask

    initial begin
        // address-dependent fill so stray reads show up
        for (int i = 0; i < 1024; i++)
            mem[i] = 32'hc3a50000 ^ (i * 32'h00010193);
        rst_n        = 1'b0;
        start_i      = 1'b0;
        mat_a_addr_i = '0;
        mat_b_addr_i = '0;
        mat_c_addr_i = '0;
        arready_i    = 1'b0;
        rvalid_i     = 1'b0;
        rid_i        = '0;
        rdata_i      = '0;
        rlast_i      = 1'b0;
        awready_i    = 1'b0;
        wready_i     = 1'b0;
        bvalid_i     = 1'b0;
        bid_i        = '0;
        bresp_i      = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("done_o", 1, done_o);
        check_value("arvalid_o", 0, arvalid_o);
        check_value("awvalid_o", 0, awvalid_o);
        check_value("wvalid_o", 0, wvalid_o);
        // small signed values, then full range at new addresses
        run_matmul(32'h0000_0100, 32'h0000_0200, 32'h0000_0300, 1'b0);
        run_matmul(32'h0000_0840, 32'h0000_0500, 32'h0000_0a00, 1'b1);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/mm_pkg.sv
common/axi_rd_if.sv
common/axi_wr_if.sv
logic/operand_buffer.sv
mm/mm_engine.sv
dma/dma_engine.sv
logic/mm_accel_top.sv
sim/mm_accel_asserts.sv
sim/mm_accel_tb.sv
